//--- testbench/core_golden.txt
# I <address> <instruction word>, D <address> <doubleword>
# W <address> <funct3> <wdata> expected stores in order
D 1100 0123456789ABCDEF
I 80000000 000010B7
I 80000004 FFB00113
I 80000008 00700193
I 8000000C 40218233
I 80000010 003122B3
I 80000014 00313333
I 80000018 40115393
I 8000001C 03C15413
I 80000020 02119493
I 80000024 FFF4851B
I 80000028 01F1959B
I 8000002C 4035D63B
I 80000030 00002697
I 80000034 0040B023
I 80000038 0050B423
I 8000003C 0060B823
I 80000040 00708C23
I 80000044 0280A023
I 80000048 0290B423
I 8000004C 02A09823
I 80000050 02B0BC23
I 80000054 04C0B023
I 80000058 04D0B423
I 8000005C 00318463
I 80000060 1000B023
I 80000064 00311463
I 80000068 1000B023
I 8000006C 00314463
I 80000070 1000B023
I 80000074 0021D463
I 80000078 1000B023
I 8000007C 0021E463
I 80000080 1000B023
I 80000084 00317463
I 80000088 1000B023
I 8000008C 00310463
I 80000090 001A0A13
I 80000094 00319463
I 80000098 001A0A13
I 8000009C 0021C463
I 800000A0 001A0A13
I 800000A4 00315463
I 800000A8 001A0A13
I 800000AC 00316463
I 800000B0 001A0A13
I 800000B4 0021F463
I 800000B8 001A0A13
I 800000BC 00800AEF
I 800000C0 1000B023
I 800000C4 00000B17
I 800000C8 00CB0BE7
I 800000CC 1000B023
I 800000D0 10008C03
I 800000D4 1000CC83
I 800000D8 10009D03
I 800000DC 1000DD83
I 800000E0 1000AE03
I 800000E4 1000EE83
I 800000E8 1000BF03
I 800000EC 0940B023
I 800000F0 0950B423
I 800000F4 0960B823
I 800000F8 0970BC23
I 800000FC 0B80B023
I 80000100 0B90B423
I 80000104 0BA0B823
I 80000108 0BB0BC23
I 8000010C 0DC0B023
I 80000110 0DD0B423
I 80000114 0DE0B823
I 80000118 0000006F
W 1000 3 000000000000000C
W 1008 3 0000000000000001
W 1010 3 0000000000000000
W 1018 0 00000000000000FD
W 1020 2 000000000000000F
W 1028 3 0000000E00000000
W 1030 1 000000000000FFFF
W 1038 3 FFFFFFFF80000000
W 1040 3 FFFFFFFFFF000000
W 1048 3 0000000080002030
W 1080 3 0000000000000006
W 1088 3 00000000800000C0
W 1090 3 00000000800000C4
W 1098 3 00000000800000CC
W 10A0 3 FFFFFFFFFFFFFFEF
W 10A8 3 00000000000000EF
W 10B0 3 FFFFFFFFFFFFCDEF
W 10B8 3 000000000000CDEF
W 10C0 3 FFFFFFFF89ABCDEF
W 10C8 3 0000000089ABCDEF
W 10D0 3 0123456789ABCDEF

//--- sources.f
design/rv_isa_pkg.sv
design/core_bus_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_load_store.sv
design/rv64_core.sv
testbench/tb_rv64_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_rv64_core -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- testbench/tb_rv64_core.sv
`default_nettype none
`timescale 1ns/100ps

module tb_rv64_core;

    localparam int STORE_TIMEOUT = 500;  // Cycles allowed per expected store
    localparam int DRAIN_CYCLES  = 40;
    localparam logic [63:0] BOOT_PC = 64'h8000_0000;  // First program word

    logic                   clk;
    logic                   reset;
    logic [31:0]            instr_i;
    logic [63:0]            pc_o;
    core_bus_pkg::mem_req_t bus_req_o;
    core_bus_pkg::mem_rsp_t bus_rsp_i;

    logic [31:0] imem [logic [63:0]];
    logic [63:0] dmem [logic [60:0]];  // Doubleword index
    logic        imem_ready;

    // Expected stores, in program order
    logic [63:0] exp_addr [$];
    logic [2:0]  exp_funct3 [$];
    logic [63:0] exp_wdata [$];

    // Stores seen on the bus
    logic [63:0] obs_addr [$];
    logic [2:0]  obs_funct3 [$];
    logic [63:0] obs_wdata [$];

    logic                   active;    // Request accepted, done pending
    logic                   done_q;    // Done given last cycle
    core_bus_pkg::mem_req_t held_req;  // Request as first seen
    int unsigned            delay;

    rv64_core DUT (
        .clk       (clk),
        .reset     (reset),
        .instr_i   (instr_i),
        .pc_o      (pc_o),
        .bus_req_o (bus_req_o),
        .bus_rsp_i (bus_rsp_i)
    );

    always #50 clk = ~clk;

    // Instruction port answers at once, NOP outside the program
    always @(pc_o or imem_ready) begin
        instr_i = (imem_ready && imem.exists(pc_o)) ? imem[pc_o] : 32'h0000_0013;
    end

    function automatic logic [63:0] read_dword(input logic [63:0] addr);
        if (dmem.exists(addr[63:3]))
            return dmem[addr[63:3]];
        return {addr[63:3], 3'b0} ^ 64'hA5A5_5A5A_C3C3_3C3C;  // Fill from address
    endfunction

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Data bus model, done 0 to 3 cycles after valid
    always @(posedge clk) begin
        #1;
        done_q         = bus_rsp_i.done;
        bus_rsp_i.done = 1'b0;
        if (!reset) begin
            active = 1'b0;
        end else begin
            // Valid must drop right after done
            assert (!(done_q && bus_req_o.valid)) else begin
                $display("Bus request still valid in the cycle after done, at %0t", $time);
                stop_on_error();
            end
            if (bus_req_o.valid) begin
                if (!active) begin
                    active   = 1'b1;
                    held_req = bus_req_o;
                    delay    = $urandom % 4;
                end
                assert (bus_req_o == held_req) else begin
                    $display("MISMATCH at %0t: bus_req_o expected %h got %h",
                             $time, held_req, bus_req_o);
                    stop_on_error();
                end
                if (delay == 0) begin
                    active         = 1'b0;
                    bus_rsp_i.done = 1'b1;
                    if (bus_req_o.write) begin
                        obs_addr.push_back(bus_req_o.addr);
                        obs_funct3.push_back(bus_req_o.funct3);
                        obs_wdata.push_back(bus_req_o.wdata);
                    end else begin
                        bus_rsp_i.rdata = read_dword(bus_req_o.addr)
                                          >> (8 * bus_req_o.addr[2:0]);
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        fd = $fopen("testbench/core_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/core_golden.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3 || line[0] == "#")
                continue;
            kind = line[0];
            n    = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c);
            case (kind)
                "I": imem[a] = b[31:0];
                "D": dmem[a[63:3]] = b;
                "W": begin
                    exp_addr.push_back(a);
                    exp_funct3.push_back(b[2:0]);
                    exp_wdata.push_back(c);
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    task automatic wait_store(input int idx);
        int cycles;
        cycles = 0;
        while (obs_addr.size() == 0) begin
            if (cycles >= STORE_TIMEOUT) begin
                $display("Timeout: store %0d to %h never arrived", idx, exp_addr[idx]);
                stop_on_error();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_store(input int idx);
        logic [63:0] addr;
        logic [2:0]  funct3;
        logic [63:0] wdata;
        addr   = obs_addr.pop_front();
        funct3 = obs_funct3.pop_front();
        wdata  = obs_wdata.pop_front();
        assert (addr == exp_addr[idx]) else begin
            $display("MISMATCH at %0t: bus_req_o.addr expected %h got %h",
                     $time, exp_addr[idx], addr);
            stop_on_error();
        end
        assert (funct3 == exp_funct3[idx]) else begin
            $display("MISMATCH at %0t: bus_req_o.funct3 expected %0d got %0d",
                     $time, exp_funct3[idx], funct3);
            stop_on_error();
        end
        assert (wdata == exp_wdata[idx]) else begin
            $display("MISMATCH at %0t: bus_req_o.wdata expected %h got %h",
                     $time, exp_wdata[idx], wdata);
            stop_on_error();
        end
    endtask

    initial begin
        void'($urandom(32'h160c_8168));
        clk        = 1'b0;
        reset      = 1'b0;
        imem_ready = 1'b0;
        active     = 1'b0;
        done_q     = 1'b0;
        held_req   = '0;
        delay      = 0;
        bus_rsp_i  = '0;
        read_golden();
        imem_ready = 1'b1;
        repeat (10) @(posedge clk);
        // Reset state, pc at boot and bus idle
        assert (pc_o == BOOT_PC) else begin
            $display("MISMATCH at %0t: pc_o expected %h got %h", $time, BOOT_PC, pc_o);
            stop_on_error();
        end
        assert (!bus_req_o.valid) else begin
            $display("MISMATCH at %0t: bus_req_o.valid expected 0 got %b",
                     $time, bus_req_o.valid);
            stop_on_error();
        end
        #1 reset = 1'b1;
        for (int i = 0; i < exp_addr.size(); i++) begin
            wait_store(i);
            check_store(i);
        end
        // Core now spins, so no further store may show up
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (obs_addr.size() != 0) begin
            $display("Extra store to %h after the last expected one", obs_addr[0]);
            stop_on_error();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- design/rv64_core.sv
`default_nettype none
`timescale 1ns/100ps

module rv64_core (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rv_isa_pkg::ILEN-1:0] instr_i,
    output logic [rv_isa_pkg::XLEN-1:0] pc_o,     // Fetch address
    output core_bus_pkg::mem_req_t      bus_req_o,
    input  core_bus_pkg::mem_rsp_t      bus_rsp_i
);

    rv_isa_pkg::instr_u          ir;          // Fetch register
    rv_isa_pkg::decoded_t        dec;
    logic                        bubble;      // Execute slot holds a flushed word
    logic [rv_isa_pkg::XLEN-1:0] ex_pc;
    logic [rv_isa_pkg::XLEN-1:0] rs1_data;
    logic [rv_isa_pkg::XLEN-1:0] rs2_data;
    logic [rv_isa_pkg::XLEN-1:0] alu_a;
    logic [rv_isa_pkg::XLEN-1:0] alu_b;
    logic [rv_isa_pkg::XLEN-1:0] alu_result;
    logic [rv_isa_pkg::XLEN-1:0] target;
    logic [rv_isa_pkg::XLEN-1:0] wb_data;
    logic [rv_isa_pkg::XLEN-1:0] load_data;
    logic                        branch_taken;
    logic                        ex_valid;
    logic                        is_mem;
    logic                        stall;
    logic                        redirect;
    logic                        wb_en;
    logic                        lsu_busy;
    logic                        load_done;

    assign ex_pc    = pc_o - 64'd4;  // pc already one word ahead
    assign ex_valid = !bubble && dec.cls != rv_isa_pkg::CLS_ILLEGAL;
    assign is_mem   = ex_valid && (dec.cls == rv_isa_pkg::CLS_LOAD
                                   || dec.cls == rv_isa_pkg::CLS_STORE);
    assign stall    = is_mem && !(lsu_busy && bus_rsp_i.done);  // Hold until done
    assign redirect = ex_valid && (dec.cls == rv_isa_pkg::CLS_JAL
                                   || dec.cls == rv_isa_pkg::CLS_JALR
                                   || (dec.cls == rv_isa_pkg::CLS_BRANCH && branch_taken));

    // AUIPC and JAL add to their own pc, JALR and memory to rs1
    assign alu_a = (dec.cls == rv_isa_pkg::CLS_AUIPC || dec.cls == rv_isa_pkg::CLS_JAL)
                   ? ex_pc : rs1_data;
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    assign target = (dec.cls == rv_isa_pkg::CLS_BRANCH) ? ex_pc + dec.imm
                                                         : {alu_result[63:1], 1'b0};

    assign wb_en = load_done || (ex_valid && dec.cls inside {rv_isa_pkg::CLS_ALU,
                   rv_isa_pkg::CLS_LUI, rv_isa_pkg::CLS_AUIPC, rv_isa_pkg::CLS_JAL,
                   rv_isa_pkg::CLS_JALR});

    always_comb begin
        case (dec.cls)
            rv_isa_pkg::CLS_LUI:  wb_data = dec.imm;
            rv_isa_pkg::CLS_JAL,
            rv_isa_pkg::CLS_JALR: wb_data = pc_o;        // Link is ex_pc + 4
            rv_isa_pkg::CLS_LOAD: wb_data = load_data;
            default:              wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o   <= core_bus_pkg::RESET_PC;
            ir     <= rv_isa_pkg::NOP;
            bubble <= 1'b0;
        end else if (!stall) begin
            bubble <= redirect;                // Kill the word fetched this cycle
            if (redirect) begin
                pc_o <= target;
            end else begin
                pc_o <= pc_o + 64'd4;
                ir   <= instr_i;
            end
        end
    end

    rv_decoder u_decoder (
        .instr_i (ir),
        .dec_o   (dec)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rd_i       (dec.rd),
        .we_i       (wb_en),
        .wdata_i    (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .op_i           (dec.alu_op),
        .word_i         (dec.word_op),
        .a_i            (alu_a),
        .b_i            (alu_b),
        .funct3_i       (dec.funct3),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    rv_load_store u_load_store (
        .clk         (clk),
        .reset       (reset),
        .start_i     (is_mem && !lsu_busy),  // One pulse per access
        .write_i     (dec.cls == rv_isa_pkg::CLS_STORE),
        .funct3_i    (dec.funct3),
        .addr_i      (alu_result),
        .wdata_i     (rs2_data),
        .busy_o      (lsu_busy),
        .load_done_o (load_done),
        .load_data_o (load_data),
        .bus_req_o   (bus_req_o),
        .bus_rsp_i   (bus_rsp_i)
    );

endmodule

`default_nettype wire

//--- design/rv_load_store.sv
`default_nettype none
`timescale 1ns/100ps

module rv_load_store (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start_i,
    input  logic                        write_i,
    input  logic [2:0]                  funct3_i,
    input  logic [rv_isa_pkg::XLEN-1:0] addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] wdata_i,
    output logic                        busy_o,
    output logic                        load_done_o,
    output logic [rv_isa_pkg::XLEN-1:0] load_data_o,
    output core_bus_pkg::mem_req_t      bus_req_o,
    input  core_bus_pkg::mem_rsp_t      bus_rsp_i
);

    typedef enum logic {LS_IDLE, LS_WAIT} ls_state_e;

    ls_state_e                   state;
    logic                        write_q;
    logic [2:0]                  funct3_q;
    logic [rv_isa_pkg::XLEN-1:0] addr_q;
    logic [rv_isa_pkg::XLEN-1:0] wdata_q;
    logic                        sext;     // LB, LH, LW

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= LS_IDLE;
        end else begin
            case (state)
                LS_IDLE: if (start_i) state <= LS_WAIT;
                default: if (bus_rsp_i.done) state <= LS_IDLE;  // Valid drops next cycle
            endcase
        end
    end

    // Access held stable for the whole request
    always_ff @(posedge clk) begin
        if (start_i && state == LS_IDLE) begin
            write_q  <= write_i;
            funct3_q <= funct3_i;
            addr_q   <= addr_i;
            case (funct3_i[1:0])
                core_bus_pkg::SIZE_B: wdata_q <= {56'b0, wdata_i[7:0]};
                core_bus_pkg::SIZE_H: wdata_q <= {48'b0, wdata_i[15:0]};
                core_bus_pkg::SIZE_W: wdata_q <= {32'b0, wdata_i[31:0]};
                default:              wdata_q <= wdata_i;
            endcase
        end
    end

    assign busy_o      = (state == LS_WAIT);
    assign load_done_o = busy_o && bus_rsp_i.done && !write_q;
    assign bus_req_o   = '{valid: busy_o, write: write_q, funct3: funct3_q,
                           addr: addr_q, wdata: wdata_q};

    assign sext = !funct3_q[2];

    always_comb begin
        case (funct3_q[1:0])
            core_bus_pkg::SIZE_B:
                load_data_o = {{56{sext & bus_rsp_i.rdata[7]}}, bus_rsp_i.rdata[7:0]};
            core_bus_pkg::SIZE_H:
                load_data_o = {{48{sext & bus_rsp_i.rdata[15]}}, bus_rsp_i.rdata[15:0]};
            core_bus_pkg::SIZE_W:
                load_data_o = {{32{sext & bus_rsp_i.rdata[31]}}, bus_rsp_i.rdata[31:0]};
            default:
                load_data_o = bus_rsp_i.rdata;  // LD
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`default_nettype none
`timescale 1ns/100ps

module rv_regfile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                              we_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       wdata_i,
    output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o
);

    logic [rv_isa_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin  // x0 never written, stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    // Read ports, no bypass needed
    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

`default_nettype wire

//--- design/rv_alu.sv
`default_nettype none
`timescale 1ns/100ps

module rv_alu (
    input  rv_isa_pkg::alu_op_e         op_i,
    input  logic                        word_i,
    input  logic [rv_isa_pkg::XLEN-1:0] a_i,
    input  logic [rv_isa_pkg::XLEN-1:0] b_i,
    input  logic [2:0]                  funct3_i,
    output logic [rv_isa_pkg::XLEN-1:0] result_o,
    output logic                        branch_taken_o
);

    logic [5:0]                  shamt;
    logic [rv_isa_pkg::XLEN-1:0] a_srl;   // Shift source, zero filled word
    logic [rv_isa_pkg::XLEN-1:0] a_sra;   // Shift source, sign filled word
    logic [rv_isa_pkg::XLEN-1:0] raw;
    logic                        cond;

    assign shamt = word_i ? {1'b0, b_i[4:0]} : b_i[5:0];
    assign a_srl = word_i ? {32'b0, a_i[31:0]} : a_i;
    assign a_sra = word_i ? {{32{a_i[31]}}, a_i[31:0]} : a_i;

    always_comb begin
        case (op_i)
            rv_isa_pkg::ALU_SUB:  raw = a_i - b_i;
            rv_isa_pkg::ALU_SLL:  raw = a_i << shamt;
            rv_isa_pkg::ALU_SLT:  raw = {63'b0, $signed(a_i) < $signed(b_i)};
            rv_isa_pkg::ALU_SLTU: raw = {63'b0, a_i < b_i};
            rv_isa_pkg::ALU_XOR:  raw = a_i ^ b_i;
            rv_isa_pkg::ALU_SRL:  raw = a_srl >> shamt;
            rv_isa_pkg::ALU_SRA:  raw = $signed(a_sra) >>> shamt;
            rv_isa_pkg::ALU_OR:   raw = a_i | b_i;
            rv_isa_pkg::ALU_AND:  raw = a_i & b_i;
            default:              raw = a_i + b_i;
        endcase
    end

    // W results sign extend from bit 31
    assign result_o = word_i ? {{32{raw[31]}}, raw[31:0]} : raw;

    // funct3[2:1] picks the compare, funct3[0] inverts it
    always_comb begin
        case (funct3_i[2:1])
            2'b00:   cond = (a_i == b_i);                  // BEQ, BNE
            2'b10:   cond = ($signed(a_i) < $signed(b_i)); // BLT, BGE
            2'b11:   cond = (a_i < b_i);                   // BLTU, BGEU
            default: cond = funct3_i[0];                   // Never taken
        endcase
    end

    assign branch_taken_o = cond ^ funct3_i[0];

endmodule

`default_nettype wire

//--- design/rv_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module rv_decoder (
    input  rv_isa_pkg::instr_u   instr_i,
    output rv_isa_pkg::decoded_t dec_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        alt;    // SUB or arithmetic shift
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] imm_j;

    assign opcode = instr_i.r_fmt.opcode;
    assign funct3 = instr_i.r_fmt.funct3;
    assign funct7 = instr_i.r_fmt.funct7;

    // SLLI/SRLI/SRAI on RV64 use bit 25 as shamt[5]
    assign alt = (opcode == rv_isa_pkg::OPC_OP_IMM) ? (funct7[6:1] == rv_isa_pkg::F7_ALT[6:1])
                                                    : (funct7 == rv_isa_pkg::F7_ALT);

    assign imm_i = {{52{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
    assign imm_s = {{52{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
    assign imm_b = {{52{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_lo[0],
                    instr_i.s_fmt.imm_hi[5:0], instr_i.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_u = {{32{instr_i.u_fmt.imm[19]}}, instr_i.u_fmt.imm, 12'b0};
    assign imm_j = {{44{instr_i.u_fmt.imm[19]}}, instr_i.u_fmt.imm[7:0],
                    instr_i.u_fmt.imm[8], instr_i.u_fmt.imm[18:9], 1'b0};

    always_comb begin
        dec_o        = '0;
        dec_o.cls    = rv_isa_pkg::CLS_ILLEGAL;  // Unknown word runs as NOP
        dec_o.alu_op = rv_isa_pkg::ALU_ADD;      // Address and link adds
        dec_o.rd     = instr_i.r_fmt.rd;
        dec_o.rs1    = instr_i.r_fmt.rs1;
        dec_o.rs2    = instr_i.r_fmt.rs2;
        dec_o.funct3 = funct3;
        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                dec_o.cls = rv_isa_pkg::CLS_LUI;
                dec_o.imm = imm_u;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                dec_o.cls     = rv_isa_pkg::CLS_AUIPC;
                dec_o.imm     = imm_u;
                dec_o.use_imm = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                dec_o.cls     = rv_isa_pkg::CLS_JAL;
                dec_o.imm     = imm_j;
                dec_o.use_imm = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) dec_o.cls = rv_isa_pkg::CLS_JALR;
                dec_o.imm     = imm_i;
                dec_o.use_imm = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) dec_o.cls = rv_isa_pkg::CLS_BRANCH;  // No 010/011
                dec_o.imm = imm_b;
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (funct3 != 3'b111) dec_o.cls = rv_isa_pkg::CLS_LOAD;
                dec_o.imm     = imm_i;
                dec_o.use_imm = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                if (!funct3[2]) dec_o.cls = rv_isa_pkg::CLS_STORE;
                dec_o.imm     = imm_s;
                dec_o.use_imm = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM_32,
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_32: begin
                dec_o.cls     = rv_isa_pkg::CLS_ALU;
                dec_o.imm     = imm_i;
                dec_o.use_imm = !opcode[5];  // Bit 5 marks register form
                dec_o.word_op = opcode[3];   // Bit 3 marks W form
                case (funct3)
                    3'b000:  dec_o.alu_op = (alt && opcode[5]) ? rv_isa_pkg::ALU_SUB
                                                               : rv_isa_pkg::ALU_ADD;
                    3'b001:  dec_o.alu_op = rv_isa_pkg::ALU_SLL;
                    3'b010:  dec_o.alu_op = rv_isa_pkg::ALU_SLT;
                    3'b011:  dec_o.alu_op = rv_isa_pkg::ALU_SLTU;
                    3'b100:  dec_o.alu_op = rv_isa_pkg::ALU_XOR;
                    3'b101:  dec_o.alu_op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                    3'b110:  dec_o.alu_op = rv_isa_pkg::ALU_OR;
                    default: dec_o.alu_op = rv_isa_pkg::ALU_AND;
                endcase
                // W forms only have add, sub and shifts
                if (opcode[3] && !(funct3 inside {3'b000, 3'b001, 3'b101}))
                    dec_o.cls = rv_isa_pkg::CLS_ILLEGAL;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

    // Access size, funct3[1:0]
    localparam logic [1:0] SIZE_B = 2'b00;
    localparam logic [1:0] SIZE_H = 2'b01;
    localparam logic [1:0] SIZE_W = 2'b10;
    localparam logic [1:0] SIZE_D = 2'b11;

    localparam logic [63:0] RESET_PC = 64'h8000_0000;

    typedef struct packed {
        logic        valid;   // Held until done
        logic        write;
        logic [2:0]  funct3;  // Size and load sign
        logic [63:0] addr;
        logic [63:0] wdata;   // Low bytes, upper zero
    } mem_req_t;

    typedef struct packed {
        logic        done;    // One-cycle pulse
        logic [63:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    localparam logic [6:0]      F7_ALT = 7'b0100000;     // SUB, SRA, SRAI
    localparam logic [ILEN-1:0] NOP    = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // Also carries the B immediate bits
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // Also carries the J immediate bits
    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        CLS_ALU, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
        CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_ILLEGAL
    } insn_class_e;

    typedef struct packed {
        insn_class_e           cls;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;      // Sign extended
        logic                  use_imm;  // Second operand is imm
        logic                  word_op;  // 32-bit W form
        logic [2:0]            funct3;
    } decoded_t;

endpackage

`default_nettype wire
